// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = hsid_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/hsid_tb_checks.svh ====
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] next_random();
  rng_state = xorshift32(rng_state);  // Shared stream for data and gaps
  return rng_state;
endfunction

task automatic fill_random(input int lib, input int wpv);
  for (int w = 0; w < wpv; w++) begin
    meas_vec[w] = next_random();  // Four random bands per word
    for (int v = 0; v < lib; v++) begin
      ref_lib[v][w] = next_random();
    end
  end
endtask

// Squared band errors summed per entry, strict minimum keeps the first index
function automatic hsid_result_t model_best(input int lib, input int wpv);
  hsid_result_t best;
  longint       sse;
  int           diff;
  best.index = '0;
  best.score = '1;  // Above any reachable sum
  for (int v = 0; v < lib; v++) begin
    sse = 0;
    for (int w = 0; w < wpv; w++) begin
      for (int b = 0; b < HSID_BANDS_PER_WORD; b++) begin
        diff = int'(meas_vec[w][b]) - int'(ref_lib[v][w][b]);
        sse += diff * diff;
      end
    end
    if (sse < longint'(best.score)) begin
      best.index = HSID_LIBRARY_WIDTH'(v);
      best.score = HSID_SCORE_WIDTH'(sse);
    end
  end
  return best;
endfunction

task automatic check_result(input string name, input hsid_result_t got,
                            input hsid_result_t exp);
  checks_run++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got index %h score %h, expected index %h score %h",
             name, got.index, got.score, exp.index, exp.score);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks_run++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  checks_run++;
  if (got != exp) begin
    error_count++;
    $display("FAIL %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic pulse_start();
  @(posedge clk);
  start <= 1'b1;
  @(posedge clk);
  start <= 1'b0;  // FSM leaves IDLE on this edge
endtask

// Valid/ready load, ready must stay high until the last word
task automatic load_measure(input int wpv);
  for (int i = 0; i < wpv; i++) begin
    meas_valid <= 1'b1;
    meas_word <= meas_vec[i];
    @(negedge clk);
    check_flag("meas_ready", meas_ready, 1'b1);
    while (!meas_ready) @(negedge clk);
    @(posedge clk);  // Word transfers here
  end
  meas_valid <= 1'b0;
  @(negedge clk);
  check_flag("meas_ready after load", meas_ready, 1'b0);
endtask

// Credit sender, one credit per word, credits come back as ref_credit pulses
task automatic send_library(input int lib, input int wpv, input int pause_max);
  int gap;
  for (int v = 0; v < lib; v++) begin
    for (int w = 0; w < wpv; w++) begin
      while (HSID_REF_DEPTH + credit_pulses - words_sent <= 0) begin
        ref_valid <= 1'b0;  // Out of credit
        @(posedge clk);
      end
      ref_valid <= 1'b1;
      ref_word <= ref_lib[v][w];
      words_sent++;
      @(posedge clk);
      gap = (pause_max > 0) ? int'(next_random() % 32'(pause_max + 1)) : 0;
      if (gap > 0) begin
        ref_valid <= 1'b0;  // Idle while still holding credits
        repeat (gap) @(posedge clk);
      end
    end
  end
  ref_valid <= 1'b0;
endtask

task automatic wait_done(input int words);
  int   limit;
  logic seen;
  limit = words * 20 + 200;
  seen = 1'b0;
  done_result = '0;
  for (int c = 0; c < limit && !seen; c++) begin
    @(negedge clk);
    if (done) begin
      seen = 1'b1;
      done_result = result;  // Result is stable while done is high
    end
  end
  if (!seen) begin
    error_count++;
    $display("done did not arrive within %0d cycles of start", limit);
  end
endtask

task automatic run_search(input int lib, input int wpv, input int pause_max,
                          output hsid_result_t got);
  hsid_result_t expected;
  int           done_before;
  int           credits_before;
  int           sent_before;
  expected = model_best(lib, wpv);
  @(posedge clk);
  library_size <= HSID_LIBRARY_WIDTH'(lib);
  words_per_vector <= HSID_PACK_WIDTH'(wpv);  // 64 words encodes as zero
  done_before = done_pulses;
  credits_before = credit_pulses;
  sent_before = words_sent;
  pulse_start();
  fork
    load_measure(wpv);
    send_library(lib, wpv, pause_max);
    wait_done(lib * wpv + wpv);
  join
  got = done_result;
  check_result("result", got, expected);
  @(negedge clk);
  check_flag("done", done, 1'b0);  // One cycle only
  check_flag("idle", idle, 1'b1);
  repeat (3) @(negedge clk);
  check_count("done pulses", done_pulses - done_before, 1);
  check_count("ref_credit pulses", credit_pulses - credits_before, words_sent - sent_before);
endtask

task automatic idle_and_load();
  hsid_result_t got;
  @(negedge clk);
  check_flag("idle", idle, 1'b1);  // Reset values
  check_flag("done", done, 1'b0);
  check_flag("meas_ready", meas_ready, 1'b0);
  check_flag("ref_credit", ref_credit, 1'b0);
  fill_random(2, 4);
  run_search(2, 4, 0, got);
endtask

task automatic random_library();
  hsid_result_t got;
  fill_random(8, 16);
  run_search(8, 16, 0, got);
endtask

task automatic exact_match_and_tie();
  hsid_result_t got;
  fill_random(4, 8);
  for (int w = 0; w < 8; w++) begin
    ref_lib[2][w] = meas_vec[w];  // Exact copy at entry 2
  end
  run_search(4, 8, 0, got);
  check_result("result exact copy", got, hsid_result_t'{index: 8'd2, score: 32'd0});
  fill_random(4, 8);
  for (int w = 0; w < 8; w++) begin
    ref_lib[1][w] = meas_vec[w];
    ref_lib[3][w] = meas_vec[w];
  end
  ref_lib[1][0][0] = meas_vec[0][0] ^ 8'h01;  // Off by one band step, score 1
  ref_lib[3][0][0] = meas_vec[0][0] ^ 8'h01;
  run_search(4, 8, 0, got);
  check_result("result tie", got, hsid_result_t'{index: 8'd1, score: 32'd1});
endtask

task automatic credit_flow();
  hsid_result_t expected;
  hsid_result_t steady;
  hsid_result_t paused;
  fill_random(8, 16);
  expected = model_best(8, 16);
  run_search(8, 16, 0, steady);
  run_search(8, 16, 6, paused);  // Same data, random sender gaps up to 6 cycles
  check_result("result without sender gaps", steady, expected);
  check_result("result with sender gaps", paused, expected);
endtask

task automatic back_to_back_runs();
  hsid_result_t got;
  fill_random(1, 1);
  run_search(1, 1, 0, got);  // Smallest shape
  fill_random(3, 64);
  run_search(3, 64, 2, got);  // Full length vectors
endtask

// ==== bench/hsid_tb.sv ====
`timescale 1ns/1ps

module hsid_tb
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
();

  localparam int CLK_HALF = 5;  // 10 ns period
  localparam int RESET_CYCLES = 10;
  localparam int LIB_MAX = 8;  // Largest library any test builds
  localparam int WATCHDOG_CYCLES =
    20 * (2 * 4 + 8 * 16 + 2 * 4 * 8 + 2 * 8 * 16 + 1 * 1 + 3 * 64) + 1000;  // Words plus margin

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          start;
  logic                          done;
  logic                          idle;
  logic [HSID_LIBRARY_WIDTH-1:0] library_size;
  logic [HSID_PACK_WIDTH-1:0]    words_per_vector;
  logic                          meas_valid;
  hsid_word_t                    meas_word;
  logic                          meas_ready;
  logic                          ref_valid;
  hsid_word_t                    ref_word;
  logic                          ref_credit;
  hsid_result_t                  result;

  hsid_word_t   meas_vec [HSID_MEAS_DEPTH];  // Measured vector of the next run
  hsid_word_t   ref_lib [LIB_MAX][HSID_MEAS_DEPTH];  // Reference library of the next run
  hsid_result_t done_result;  // Result sampled with done
  logic [31:0]  rng_state;
  int           error_count = 0;
  int           checks_run = 0;
  int           credit_pulses = 0;  // Credits handed back by the FIFO
  int           words_sent = 0;  // Credits spent by the sender
  int           done_pulses = 0;

  always #CLK_HALF clk = ~clk;

  // Protocol pulses counted mid-cycle
  always @(negedge clk) begin
    if (ref_credit) credit_pulses++;
    if (done) done_pulses++;
  end

  hsid_top dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .done            (done),
    .idle            (idle),
    .library_size    (library_size),
    .words_per_vector(words_per_vector),
    .meas_valid      (meas_valid),
    .meas_word       (meas_word),
    .meas_ready      (meas_ready),
    .ref_valid       (ref_valid),
    .ref_word        (ref_word),
    .ref_credit      (ref_credit),
    .result          (result)
  );

  `include "hsid_tb_checks.svh"

  initial begin
    rng_state = 32'h84e33569;
    rst_n = 1'b0;  // Held for the first cycles
    start = 1'b0;
    library_size = '0;
    words_per_vector = '0;
    meas_valid = 1'b0;
    meas_word = '0;
    ref_valid = 1'b0;
    ref_word = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    idle_and_load();
    random_library();
    exact_match_and_tie();
    credit_flow();
    back_to_back_runs();
    repeat (4) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks_run, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the word count of all runs
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test sequence stalled", WATCHDOG_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks_run, error_count + 1);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+bench
logic/hsid_cfg_pkg.sv
logic/hsid_types_pkg.sv
logic/hsid_main_fsm.sv
logic/hsid_measure_buf.sv
logic/hsid_ref_fifo.sv
logic/hsid_sse_acc.sv
logic/hsid_min_select.sv
logic/hsid_top.sv
bench/hsid_tb.sv

// ==== logic/hsid_cfg_pkg.sv ====
package hsid_cfg_pkg;

  // Bus and band geometry
  localparam int HSID_WORD_WIDTH = 32;  // One bus word
  localparam int HSID_DATA_WIDTH = 8;  // One unsigned band
  localparam int HSID_BANDS_PER_WORD = HSID_WORD_WIDTH / HSID_DATA_WIDTH;  // Four bands

  // Vector and library sizes
  localparam int HSID_PACK_WIDTH = 6;  // Word count of one vector, zero means 64
  localparam int HSID_LIBRARY_WIDTH = 8;  // Library index
  localparam int HSID_SCORE_WIDTH = 32;  // Accumulated squared error

  // Buffer depths
  localparam int HSID_REF_DEPTH = 8;  // Also the sender's initial credit count
  localparam int HSID_MEAS_DEPTH = 2 ** HSID_PACK_WIDTH;  // Whole measured vector
  localparam int HSID_REF_PTR_WIDTH = $clog2(HSID_REF_DEPTH);
  localparam logic [HSID_REF_PTR_WIDTH:0] HSID_REF_FULL_COUNT =
    (HSID_REF_PTR_WIDTH + 1)'(HSID_REF_DEPTH);  // Fill level when full

  // Datapath widths inside the accumulator
  localparam int HSID_SQ_WIDTH = 2 * HSID_DATA_WIDTH;  // One squared band
  localparam int HSID_WSUM_WIDTH = HSID_SQ_WIDTH + $clog2(HSID_BANDS_PER_WORD);  // Word sum

  localparam int HSID_STATE_WIDTH = 3;  // Main FSM encoding

endpackage

// ==== logic/hsid_main_fsm.sv ====
`timescale 1ns/1ps

module hsid_main_fsm
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  hsid_cfg_t                     cfg,  // Library size and vector length
  input  logic                          fifo_measure_complete,  // Measured vector loaded
  input  logic                          fifo_ref_empty,
  output logic                          fifo_both_read_en,  // Pops FIFO and replay together
  input  logic                          msi_valid,  // Score out of the accumulator
  input  logic                          msi_comparison_valid,  // Final minimum ready
  input  hsid_word_t                    meas_word,  // Show-ahead replay word
  input  hsid_word_t                    ref_word,  // Show-ahead FIFO word
  output hsid_elem_t                    elem,
  output logic [HSID_LIBRARY_WIDTH-1:0] vctr_count,  // Vectors issued so far
  output hsid_main_state_t              state,
  input  logic                          start,
  output logic                          done,
  output logic                          idle,
  output logic                          ready
);

  hsid_main_state_t              state_next;
  logic [HSID_PACK_WIDTH-1:0]    word_cnt;  // Word position inside the vector
  logic [HSID_PACK_WIDTH-1:0]    word_last_idx;
  logic [HSID_LIBRARY_WIDTH-1:0] vctr_last_idx;
  logic                          word_last;
  logic                          vctr_last;
  logic                          run_clear;

  assign word_last_idx = cfg.words_per_vector - 1'b1;  // Zero wraps to 63
  assign vctr_last_idx = cfg.library_size - 1'b1;  // Zero wraps to 255
  assign word_last = (word_cnt == word_last_idx);
  assign vctr_last = (vctr_count == vctr_last_idx);
  assign run_clear = (state == IDLE) && start;  // New run accepted

  // Replay buffer never runs dry once loaded so only the FIFO gates a pop
  assign fifo_both_read_en = (state == COMPUTE_MSE) && !fifo_ref_empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Word and vector counters advance on each pop, stall otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      vctr_count <= '0;
    end else if (run_clear) begin
      word_cnt <= '0;  // Fresh run
      vctr_count <= '0;
    end else if (fifo_both_read_en) begin
      if (word_last) begin
        word_cnt <= '0;  // Wrap at vector length
        vctr_count <= vctr_count + 1'b1;  // Moves on as the last word leaves
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // Element pair registered one cycle after its pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      elem <= '0;
    end else begin
      elem.valid <= fifo_both_read_en;
      elem.start <= fifo_both_read_en && (word_cnt == '0);
      elem.last <= fifo_both_read_en && word_last;
      elem.meas_word <= meas_word;  // Data sampled with the pop
      elem.ref_word <= ref_word;
    end
  end

  always_comb begin
    state_next = state;  // Hold by default
    idle = 1'b0;
    ready = 1'b0;
    done = 1'b0;
    case (state)
      IDLE: begin
        idle = 1'b1;
        if (start) state_next = READ_MEASURE;
      end
      READ_MEASURE: begin
        ready = !fifo_measure_complete;  // Drops once the vector is in
        if (fifo_measure_complete) state_next = COMPUTE_MSE;
      end
      COMPUTE_MSE: begin
        if (fifo_both_read_en && word_last && vctr_last) state_next = WAIT_MSE;  // Final pop
      end
      WAIT_MSE: begin
        if (msi_valid) state_next = COMPARE_MSE;  // Scores draining
      end
      COMPARE_MSE: begin
        if (msi_comparison_valid) state_next = DONE;  // Last score compared
      end
      DONE: begin
        done = 1'b1;  // Single cycle with result
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

endmodule

// ==== logic/hsid_measure_buf.sv ====
`timescale 1ns/1ps

module hsid_measure_buf
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,  // Clears pointers for a new run
  input  hsid_cfg_t  cfg,
  input  logic       wr_en,
  input  hsid_word_t wr_word,
  input  logic       rd_en,  // Advance replay pointer
  output hsid_word_t rd_word,
  output logic       fifo_measure_complete
);

  hsid_word_t                 mem [HSID_MEAS_DEPTH];  // One measured vector
  logic [HSID_PACK_WIDTH-1:0] wr_ptr;
  logic [HSID_PACK_WIDTH-1:0] rd_ptr;
  logic [HSID_PACK_WIDTH-1:0] last_ptr;
  logic                       wr_ok;

  assign last_ptr = cfg.words_per_vector - 1'b1;  // Zero selects all 64 entries
  assign wr_ok = wr_en && !fifo_measure_complete;  // Extra words ignored
  assign rd_word = mem[rd_ptr];  // Show-ahead replay

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Load side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      fifo_measure_complete <= 1'b0;
    end else if (start) begin
      wr_ptr <= '0;
      fifo_measure_complete <= 1'b0;
    end else if (wr_ok) begin
      if (wr_ptr == last_ptr) begin
        wr_ptr <= '0;
        fifo_measure_complete <= 1'b1;  // High from the next cycle
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Replay side wraps so every library entry sees the whole vector
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (start) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
    end
  end

endmodule

// ==== logic/hsid_min_select.sv ====
`timescale 1ns/1ps

module hsid_min_select
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,  // New run
  input  hsid_cfg_t    cfg,
  input  hsid_score_t  score,
  output hsid_result_t result,  // Best so far
  output logic         msi_comparison_valid
);

  logic [HSID_LIBRARY_WIDTH-1:0] score_cnt;  // Scores seen this run
  logic [HSID_LIBRARY_WIDTH-1:0] last_cnt;
  logic                          lower;

  assign last_cnt = cfg.library_size - 1'b1;  // Zero means 256 entries
  assign lower = (score.score < result.score);  // Strict so ties keep the earlier index

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result.index <= '0;
      result.score <= '1;
      score_cnt <= '0;
      msi_comparison_valid <= 1'b0;
    end else if (start) begin
      result.index <= '0;
      result.score <= '1;  // Any real score beats this
      score_cnt <= '0;
      msi_comparison_valid <= 1'b0;
    end else begin
      msi_comparison_valid <= score.valid && (score_cnt == last_cnt);  // Final score
      if (score.valid) begin
        score_cnt <= score_cnt + 1'b1;
        if (lower) begin
          result.index <= score.index;
          result.score <= score.score;
        end
      end
    end
  end

endmodule

// ==== logic/hsid_ref_fifo.sv ====
`timescale 1ns/1ps

module hsid_ref_fifo
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  hsid_word_t push_word,
  input  logic       pop,
  output hsid_word_t pop_word,  // Head entry, valid while not empty
  output logic       empty,
  output logic       credit  // One pulse per word popped
);

  hsid_word_t                    mem [HSID_REF_DEPTH];
  logic [HSID_REF_PTR_WIDTH-1:0] wr_ptr;  // Wraps naturally at depth
  logic [HSID_REF_PTR_WIDTH-1:0] rd_ptr;
  logic [HSID_REF_PTR_WIDTH:0]   count;  // Fill level
  logic                          full;
  logic                          push_ok;
  logic                          pop_ok;

  assign empty = (count == '0);
  assign full = (count == HSID_REF_FULL_COUNT);
  assign push_ok = push && !full;  // Sender error otherwise, word dropped
  assign pop_ok = pop && !empty;
  assign pop_word = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop_ok;  // Slot freed, hand it back
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// ==== logic/hsid_sse_acc.sv ====
`timescale 1ns/1ps

module hsid_sse_acc
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  hsid_elem_t                    elem,
  input  logic [HSID_LIBRARY_WIDTH-1:0] vctr_index,  // Issue counter from the FSM
  output hsid_score_t                   score
);

  logic [HSID_DATA_WIDTH-1:0]    band_diff [HSID_BANDS_PER_WORD];  // Absolute differences
  logic [HSID_SQ_WIDTH-1:0]      band_sq [HSID_BANDS_PER_WORD];
  logic [HSID_SQ_WIDTH-1:0]      s1_sq [HSID_BANDS_PER_WORD];
  logic                          s1_valid;
  logic                          s1_start;
  logic                          s1_last;
  logic [HSID_LIBRARY_WIDTH-1:0] s1_index;
  logic [HSID_WSUM_WIDTH-1:0]    word_sum;
  logic [HSID_WSUM_WIDTH-1:0]    s2_sum;
  logic                          s2_valid;
  logic                          s2_start;
  logic                          s2_last;
  logic [HSID_LIBRARY_WIDTH-1:0] s2_index;
  logic [HSID_SCORE_WIDTH-1:0]   acc_sum;  // Running total of the vector
  logic [HSID_SCORE_WIDTH-1:0]   acc_next;

  // Stage one square
  always_comb begin
    for (int b = 0; b < HSID_BANDS_PER_WORD; b++) begin
      band_diff[b] = (elem.meas_word[b] > elem.ref_word[b]) ?
                     elem.meas_word[b] - elem.ref_word[b] :
                     elem.ref_word[b] - elem.meas_word[b];
      band_sq[b] = band_diff[b] * band_diff[b];
    end
  end

  // Stage two word sum
  always_comb begin
    word_sum = '0;
    for (int b = 0; b < HSID_BANDS_PER_WORD; b++) begin
      word_sum = word_sum + HSID_WSUM_WIDTH'(s1_sq[b]);
    end
  end

  // Stage three restarts on the first word of a vector
  assign acc_next = (s2_start ? '0 : acc_sum) + HSID_SCORE_WIDTH'(s2_sum);

  always_ff @(posedge clk) begin
    s1_sq <= band_sq;
    s1_index <= vctr_index - 1'b1;  // Counter already stepped past a last word
    s2_sum <= word_sum;
    s2_index <= s1_index;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_start <= 1'b0;
      s1_last <= 1'b0;
      s2_valid <= 1'b0;
      s2_start <= 1'b0;
      s2_last <= 1'b0;
      acc_sum <= '0;
      score <= '0;
    end else begin
      s1_valid <= elem.valid;
      s1_start <= elem.start;
      s1_last <= elem.last;
      s2_valid <= s1_valid;
      s2_start <= s1_start;
      s2_last <= s1_last;
      if (s2_valid) acc_sum <= acc_next;
      score.valid <= s2_valid && s2_last;  // Three cycles after the last element
      if (s2_valid && s2_last) begin
        score.score <= acc_next;
        score.index <= s2_index;
      end
    end
  end

endmodule

// ==== logic/hsid_top.sv ====
`timescale 1ns/1ps

module hsid_top
  import hsid_cfg_pkg::*;
  import hsid_types_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  output logic                          done,
  output logic                          idle,
  input  logic [HSID_LIBRARY_WIDTH-1:0] library_size,
  input  logic [HSID_PACK_WIDTH-1:0]    words_per_vector,  // Zero means 64
  input  logic                          meas_valid,
  input  hsid_word_t                    meas_word,
  output logic                          meas_ready,
  input  logic                          ref_valid,  // Sender holds a credit
  input  hsid_word_t                    ref_word,
  output logic                          ref_credit,
  output hsid_result_t                  result
);

  hsid_cfg_t                     cfg;
  hsid_main_state_t              fsm_state;
  hsid_word_t                    replay_word;  // Measure buffer head
  hsid_word_t                    fifo_word;  // Ref FIFO head
  hsid_elem_t                    elem;
  hsid_score_t                   score;
  logic [HSID_LIBRARY_WIDTH-1:0] vctr_count;
  logic                          fifo_both_read_en;
  logic                          fifo_measure_complete;
  logic                          fifo_ref_empty;
  logic                          msi_comparison_valid;
  logic                          run_start;
  logic                          meas_wr_en;

  assign cfg = '{library_size: library_size, words_per_vector: words_per_vector};
  assign run_start = start && (fsm_state == IDLE);  // Only a start the FSM accepts
  assign meas_wr_en = meas_valid && meas_ready;  // Handshake transfer

  hsid_main_fsm fsm0 (
    .clk                  (clk),
    .rst_n                (rst_n),
    .cfg                  (cfg),
    .fifo_measure_complete(fifo_measure_complete),
    .fifo_ref_empty       (fifo_ref_empty),
    .fifo_both_read_en    (fifo_both_read_en),
    .msi_valid            (score.valid),
    .msi_comparison_valid (msi_comparison_valid),
    .meas_word            (replay_word),
    .ref_word             (fifo_word),
    .elem                 (elem),
    .vctr_count           (vctr_count),
    .state                (fsm_state),
    .start                (start),
    .done                 (done),
    .idle                 (idle),
    .ready                (meas_ready)
  );

  hsid_measure_buf mbuf0 (
    .clk                  (clk),
    .rst_n                (rst_n),
    .start                (run_start),
    .cfg                  (cfg),
    .wr_en                (meas_wr_en),
    .wr_word              (meas_word),
    .rd_en                (fifo_both_read_en),
    .rd_word              (replay_word),
    .fifo_measure_complete(fifo_measure_complete)
  );

  hsid_ref_fifo rfifo0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (ref_valid),
    .push_word(ref_word),
    .pop      (fifo_both_read_en),
    .pop_word (fifo_word),
    .empty    (fifo_ref_empty),
    .credit   (ref_credit)
  );

  hsid_sse_acc acc0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .elem      (elem),
    .vctr_index(vctr_count),
    .score     (score)
  );

  hsid_min_select msel0 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .start               (run_start),
    .cfg                 (cfg),
    .score               (score),
    .result              (result),
    .msi_comparison_valid(msi_comparison_valid)
  );

endmodule

// ==== logic/hsid_types_pkg.sv ====
package hsid_types_pkg;

  import hsid_cfg_pkg::*;

  // Main sequencer states
  typedef enum logic [HSID_STATE_WIDTH-1:0] {
    IDLE,
    READ_MEASURE,
    COMPUTE_MSE,
    WAIT_MSE,
    COMPARE_MSE,
    DONE
  } hsid_main_state_t;

  // Four bands packed in one bus word, band 0 in the low byte
  typedef logic [HSID_BANDS_PER_WORD-1:0][HSID_DATA_WIDTH-1:0] hsid_word_t;

  typedef struct packed {
    hsid_word_t meas_word;  // Replayed measured word
    hsid_word_t ref_word;  // Reference word from the FIFO
    logic       valid;
    logic       start;  // First word of a vector
    logic       last;  // Final word of a vector
  } hsid_elem_t;

  typedef struct packed {
    logic [HSID_SCORE_WIDTH-1:0]   score;  // Sum of squared errors
    logic [HSID_LIBRARY_WIDTH-1:0] index;  // Library entry it belongs to
    logic                          valid;
  } hsid_score_t;

  typedef struct packed {
    logic [HSID_LIBRARY_WIDTH-1:0] index;  // Closest library entry
    logic [HSID_SCORE_WIDTH-1:0]   score;  // Its score
  } hsid_result_t;

  typedef struct packed {
    logic [HSID_LIBRARY_WIDTH-1:0] library_size;  // Zero means full library
    logic [HSID_PACK_WIDTH-1:0]    words_per_vector;  // Zero means 64 words
  } hsid_cfg_t;

endpackage
